/* verilog.f */
design/phy_cmd_pkg.sv
design/cmd_decoder.sv
design/cmd_slot_map.sv
design/tri_sequencer.sv
design/phy_cmd_top.sv
bench/tb_phy_cmd.sv

/* run.sh */
#!/bin/sh
# compile and run the command front end testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_phy_cmd --Mdir obj_dir -f verilog.f
./obj_dir/Vtb_phy_cmd
exit 0

/* bench/tb_phy_cmd.sv */
// ##########################################################
// testbench for the DDR3 PHY command front end, random
// command words checked against a reference decoder model
// ##########################################################
`timescale 1ns/1ps

module tb_phy_cmd import phy_cmd_pkg::*; ();

    localparam int PAUSE_BITS   = 10;
    localparam int DONE_BIT     = 10;
    localparam int PERIOD       = 8;    // ns
    localparam int RESET_CYCLES = 16;
    localparam int N_CYCLES     = 3000; // random command words after reset
    localparam int TIMEOUT_NS   = (2 * N_CYCLES + RESET_CYCLES) * PERIOD;

    typedef logic [PAUSE_BITS-1:0] pause_len_t;

    logic         mclk;
    logic         mrst;
    cmd_word_t    cmd_word;
    logic         add_pause;
    logic         ddr_cke;
    tri_word_t    dqs_pattern;
    tri_pattern_t dq_tri_on;
    tri_pattern_t dq_tri_off;
    tri_pattern_t dqs_tri_on;
    tri_pattern_t dqs_tri_off;
    phy_slots_t   slots;
    tri_word_t    dq_tri;
    tri_word_t    dqs_tri;
    tri_word_t    dqs_data;
    logic         dci_dis_dq;
    logic         dci_dis_dqs;
    logic         cmd_nop;
    logic         add_pause_req;
    pause_len_t   pause_len;
    logic         sequence_done;
    logic         buf_wr;
    logic         buf_rd;
    logic         buf_rst;

    cmd_word_t    held;      // model copy of the last non-nop word, rcw cleared
    logic         dq_prev;   // model tristate history
    logic         dqs_prev;
    cmd_word_t    act;       // active view of the current cycle
    logic         exp_nop;
    int           n_checks;  // compared cycles
    logic [31:0]  rng;       // xorshift state
    logic [31:0]  r;
    cmd_word_t    w;
    logic         last_dq;   // keeps enables steady for a few cycles
    logic         last_dqs;

    phy_cmd_top #(
        .CMD_PAUSE_BITS (PAUSE_BITS),
        .CMD_DONE_BIT   (DONE_BIT)
    ) dut (.*);

    initial mclk = 1'b0;
    always #(PERIOD/2) mclk = ~mclk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // controls and calm address seen by the PHY this cycle
    function automatic cmd_word_t active_word(input cmd_word_t cw, input logic ap,
                                              input cmd_word_t h);
        cmd_word_t a;
        a = ap ? h : cw;                  // a pause replays the held copy
        if (!ap && cw.rcw == '0) begin
            a.addr = h.addr;              // plain nop keeps pins calm
            a.bank = h.bank;
        end
        return a;
    endfunction

    function automatic phy_slots_t exp_slots(input cmd_word_t a, input logic cke_in);
        phy_slots_t s;
        logic [2:0] cmd_n;
        int         k;
        int         i;
        cmd_n = ~a.rcw;
        k     = a.sel ? 1 : 0;            // slot 1 is the first half-cycle
        for (i = 0; i < 2; i++) begin
            s.addr[i]  = a.addr;
            s.bank[i]  = a.bank;
            s.ras_n[i] = 1'b1;            // nop unless chosen below
            s.cas_n[i] = 1'b1;
            s.we_n[i]  = 1'b1;
            s.cke[i]   = a.cke_dis ^ cke_in;
            s.odt[i]   = a.odt;
        end
        s.ras_n[k] = cmd_n[2];
        s.cas_n[k] = cmd_n[1];
        s.we_n[k]  = cmd_n[0];
        return s;
    endfunction

    function automatic tri_word_t exp_tri(input logic en, input logic prev,
                                          input tri_pattern_t on, input tri_pattern_t off);
        logic      t;
        tri_word_t word;
        t = !en;
        if (t == prev)  word = {8{t}};    // no change
        else if (prev)  word = {on, on};  // leaving tristate
        else            word = {off, off};
        return word;
    endfunction

    task automatic check_slots(input string name, input phy_slots_t exp,
                               input phy_slots_t got);
        if (got !== exp) begin
            $display("** Error %s cycle %0d: expected %h, actual %h", name, n_checks, exp, got);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_tri(input string name, input tri_word_t exp, input tri_word_t got);
        if (got !== exp) begin
            $display("** Error %s cycle %0d: expected %h, actual %h", name, n_checks, exp, got);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input pause_len_t exp, input pause_len_t got);
        if (got !== exp) begin
            $display("** Error %s cycle %0d: expected %h, actual %h", name, n_checks, exp, got);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // compare 1 ns before the rising edge, then step the model
    always begin
        @(negedge mclk);
        #(PERIOD/2 - 1);
        if (mrst) begin
            held     = '0;
            dq_prev  = 1'b1;              // tristated after reset
            dqs_prev = 1'b1;
        end else begin
            act     = active_word(cmd_word, add_pause, held);
            exp_nop = (cmd_word.rcw == '0) && !add_pause;
            check_slots("slots", exp_slots(act, ddr_cke), slots);
            check_tri("dq_tri", exp_tri(act.dq_en, dq_prev, dq_tri_on, dq_tri_off), dq_tri);
            check_tri("dqs_tri", exp_tri(act.dqs_en, dqs_prev, dqs_tri_on, dqs_tri_off),
                      dqs_tri);
            check_tri("dqs_data", act.dqs_toggle ? dqs_pattern : '0, dqs_data);
            check_bit("dci_dis_dq", pause_len_t'(!act.dci_en), pause_len_t'(dci_dis_dq));
            check_bit("dci_dis_dqs", pause_len_t'(!act.dci_en || act.odt),
                      pause_len_t'(dci_dis_dqs));
            check_bit("cmd_nop", pause_len_t'(exp_nop), pause_len_t'(cmd_nop));
            check_bit("sequence_done", pause_len_t'(exp_nop && cmd_word.addr[DONE_BIT]),
                      pause_len_t'(sequence_done));
            check_bit("pause_len", cmd_word.addr[DONE_BIT] ? '0 :
                      pause_len_t'(cmd_word.addr[PAUSE_BITS-1:0]), pause_len);
            check_bit("add_pause_req", pause_len_t'(cmd_word.add_pause_req),
                      pause_len_t'(add_pause_req));
            check_bit("buf_wr", pause_len_t'(act.buf_wr), pause_len_t'(buf_wr));
            check_bit("buf_rd", pause_len_t'(act.buf_rd), pause_len_t'(buf_rd));
            check_bit("buf_rst", pause_len_t'(act.buf_rst), pause_len_t'(buf_rst));
            dq_prev  = !act.dq_en;
            dqs_prev = !act.dqs_en;
            if (!exp_nop) begin
                held     = cmd_word;      // added pauses load the word too
                held.rcw = '0;
            end
            n_checks++;
        end
    end

    initial begin
        mrst        = 1'b1;
        cmd_word    = '0;
        add_pause   = 1'b0;
        ddr_cke     = 1'b1;
        dqs_pattern = 8'h55;
        dq_tri_on   = 4'h0;
        dq_tri_off  = 4'hf;
        dqs_tri_on  = 4'h0;
        dqs_tri_off = 4'hf;
        rng         = 32'h271c;
        n_checks    = 0;
        last_dq     = 1'b0;
        last_dqs    = 1'b0;
        repeat (RESET_CYCLES) @(posedge mclk);
        for (int i = 0; i < N_CYCLES; i++) begin
            @(negedge mclk);
            mrst = 1'b0;
            rng  = xorshift(rng);
            r    = rng;
            rng  = xorshift(rng);
            w    = cmd_word_t'(rng);
            if (r[3:2] == 2'b00) w.rcw = '0;            // about a quarter nops
            w.addr[DONE_BIT] = (r[5:4] == 2'b00);       // done on some words
            if (r[7:6] != 2'b00) w.dq_en = last_dq;     // enables change now and then
            if (r[9:8] != 2'b00) w.dqs_en = last_dqs;
            last_dq     = w.dq_en;
            last_dqs    = w.dqs_en;
            cmd_word    = w;
            add_pause   = (i == 0) || (r[1:0] == 2'b00); // first one replays reset state
            ddr_cke     = (r[11:10] != 2'b00);
            rng         = xorshift(rng);
            dqs_pattern = rng[7:0];
            dq_tri_on   = rng[11:8];
            dq_tri_off  = rng[15:12];
            dqs_tri_on  = rng[19:16];
            dqs_tri_off = rng[23:20];
        end
        @(negedge mclk);
        if (n_checks == N_CYCLES) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "only %0d of %0d cycles were compared", n_checks, N_CYCLES);
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "timeout, the run did not finish within %0d ns", TIMEOUT_NS);
    end

endmodule

/* design/phy_cmd_top.sv */
// ##########################################################
// DDR3 PHY command front end, decodes one command word per
// mclk into half-cycle slots, tristate words and status
// ##########################################################
`timescale 1ns/1ps

module phy_cmd_top import phy_cmd_pkg::*; #(
    parameter int CMD_PAUSE_BITS = 10, // address bits that encode a pause
    parameter int CMD_DONE_BIT   = 10  // address bit for sequence done
) (
    input  logic                      mclk,          // half the DDR3 clock
    input  logic                      mrst,          // sync, active high
    input  cmd_word_t                 cmd_word,
    input  logic                      add_pause,     // replay last command as nop
    input  logic                      ddr_cke,
    input  tri_word_t                 dqs_pattern,
    input  tri_pattern_t              dq_tri_on,
    input  tri_pattern_t              dq_tri_off,
    input  tri_pattern_t              dqs_tri_on,
    input  tri_pattern_t              dqs_tri_off,
    output phy_slots_t                slots,         // to the PHY command pins
    output tri_word_t                 dq_tri,
    output tri_word_t                 dqs_tri,
    output tri_word_t                 dqs_data,
    output logic                      dci_dis_dq,
    output logic                      dci_dis_dqs,
    output logic                      cmd_nop,
    output logic                      add_pause_req,
    output logic [CMD_PAUSE_BITS-1:0] pause_len,
    output logic                      sequence_done,
    output logic                      buf_wr,        // external buffer strobes
    output logic                      buf_rd,
    output logic                      buf_rst
);

    typedef logic [CMD_PAUSE_BITS-1:0] pause_len_t;

    cmd_ctrl_t  ctrl;          // decoded controls for this cycle
    row_addr_t  addr_calm;
    bank_t      bank_calm;
    pause_len_t dec_pause_len;

    cmd_decoder #(
        .CMD_PAUSE_BITS (CMD_PAUSE_BITS),
        .CMD_DONE_BIT   (CMD_DONE_BIT)
    ) decoder (
        .mclk          (mclk),
        .mrst          (mrst),
        .cmd_word      (cmd_word),
        .add_pause     (add_pause),
        .ctrl          (ctrl),
        .addr_calm     (addr_calm),
        .bank_calm     (bank_calm),
        .cmd_nop       (cmd_nop),
        .sequence_done (sequence_done),
        .pause_len     (dec_pause_len),
        .add_pause_req (add_pause_req),
        .buf_wr        (buf_wr),
        .buf_rd        (buf_rd),
        .buf_rst       (buf_rst)
    );

    assign pause_len = dec_pause_len;

    cmd_slot_map slot_map (
        .ctrl        (ctrl),
        .addr_calm   (addr_calm),
        .bank_calm   (bank_calm),
        .ddr_cke     (ddr_cke),
        .dqs_pattern (dqs_pattern),
        .slots       (slots),
        .dci_dis_dq  (dci_dis_dq),
        .dci_dis_dqs (dci_dis_dqs),
        .dqs_data    (dqs_data)
    );

    tri_sequencer dq_seq (       // DQ lines
        .mclk     (mclk),
        .mrst     (mrst),
        .en       (ctrl.dq_en),
        .tri_on   (dq_tri_on),
        .tri_off  (dq_tri_off),
        .tri_word (dq_tri)
    );

    tri_sequencer dqs_seq (      // DQS lines
        .mclk     (mclk),
        .mrst     (mrst),
        .en       (ctrl.dqs_en),
        .tri_on   (dqs_tri_on),
        .tri_off  (dqs_tri_off),
        .tri_word (dqs_tri)
    );

endmodule

/* design/tri_sequencer.sv */
// ##########################################################
// output enable to 8-slot tristate word, inserts the on/off
// transition pattern for one cycle on each change
// ##########################################################
`timescale 1ns/1ps

module tri_sequencer import phy_cmd_pkg::*; (
    input  logic         mclk,
    input  logic         mrst,     // sync, active high
    input  logic         en,       // drive the lines this cycle
    input  tri_pattern_t tri_on,   // first word when enabling
    input  tri_pattern_t tri_off,  // first word after disabling
    output tri_word_t    tri_word  // 1 = tristated
);

    logic tri_cur;  // current tristate level
    logic tri_prev; // level of the previous cycle

    assign tri_cur = ~en;

    always_ff @(posedge mclk) begin
        if (mrst) tri_prev <= 1'b1; // lines start tristated
        else      tri_prev <= tri_cur;
    end

    always_comb begin
        if (tri_cur == tri_prev) begin
            tri_word = {8{tri_cur}};       // steady, uniform word
        end else if (tri_prev) begin
            tri_word = {tri_on, tri_on};   // turning the driver on
        end else begin
            tri_word = {tri_off, tri_off}; // turning it off
        end
    end

    // a level held over two cycles outside reset gives no pattern
    assert property (@(posedge mclk) disable iff (mrst)
        ($stable(tri_cur) && !$past(mrst)) |-> (tri_word == {8{tri_cur}}))
        else $error("transition pattern on a steady level");

endmodule

/* design/cmd_slot_map.sv */
// ##########################################################
// places one decoded command into the two DDR3 half-cycle
// slots, forms CKE, ODT, DCI disables and DQS toggle data
// ##########################################################
`timescale 1ns/1ps

module cmd_slot_map import phy_cmd_pkg::*; (
    input  cmd_ctrl_t  ctrl,        // controls after pause substitution
    input  row_addr_t  addr_calm,
    input  bank_t      bank_calm,
    input  logic       ddr_cke,     // global CKE level
    input  tri_word_t  dqs_pattern, // usually 8'h55
    output phy_slots_t slots,
    output logic       dci_dis_dq,
    output logic       dci_dis_dqs,
    output tri_word_t  dqs_data
);

    rcw_t [1:0] slot_rcw_n; // per slot {ras_n,cas_n,we_n}
    rcw_t       rcw_n;      // active low command code
    logic       cke;

    assign rcw_n = ~ctrl.rcw;
    assign cke   = ctrl.cke_dis ^ ddr_cke; // command bit flips the global level

    // sel picks the half-cycle, the other one idles as nop
    always_comb begin
        slot_rcw_n[1] = ctrl.sel ? rcw_n : '1;
        slot_rcw_n[0] = ctrl.sel ? '1 : rcw_n;
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            slots.addr[i]  = addr_calm;      // same address in both halves
            slots.bank[i]  = bank_calm;
            slots.ras_n[i] = slot_rcw_n[i][2];
            slots.cas_n[i] = slot_rcw_n[i][1];
            slots.we_n[i]  = slot_rcw_n[i][0];
            slots.cke[i]   = cke;
            slots.odt[i]   = ctrl.odt;
        end
    end

    assign dci_dis_dq = ~ctrl.dci_en;
    // write leveling has dci_en=1 with odt=1, DCI then stays on DQ only
    assign dci_dis_dqs = ~ctrl.dci_en | ctrl.odt;

    // DQS must stay low when not toggling, write leveling preamble needs it
    assign dqs_data = ctrl.dqs_toggle ? dqs_pattern : '0;

endmodule

/* design/cmd_decoder.sv */
// ##########################################################
// command word decoder, holds the last active command and
// replays it on added pauses, keeps address and bank calm
// ##########################################################
`timescale 1ns/1ps

module cmd_decoder import phy_cmd_pkg::*; #(
    parameter int CMD_PAUSE_BITS = 10, // address bits that carry the pause length
    parameter int CMD_DONE_BIT   = 10  // address bit that flags sequence done
) (
    input  logic                      mclk,
    input  logic                      mrst,          // sync, active high
    input  cmd_word_t                 cmd_word,      // one word per mclk
    input  logic                      add_pause,     // repeat previous command as nop
    output cmd_ctrl_t                 ctrl,          // controls after substitution
    output row_addr_t                 addr_calm,     // frozen during nops and pauses
    output bank_t                     bank_calm,
    output logic                      cmd_nop,       // word is a nop, not an added pause
    output logic                      sequence_done,
    output logic [CMD_PAUSE_BITS-1:0] pause_len,
    output logic                      add_pause_req,
    output logic                      buf_wr,
    output logic                      buf_rd,
    output logic                      buf_rst
);

    typedef logic [CMD_PAUSE_BITS-1:0] pause_len_t;

    cmd_ctrl_t  ctrl_word;  // controls straight from the word
    cmd_ctrl_t  ctrl_pause; // same with rcw forced to nop, what gets held
    cmd_ctrl_t  ctrl_held;  // replayed while add_pause is high
    row_addr_t  addr_held;  // last address of a non-nop cycle
    bank_t      bank_held;
    pause_len_t pause_raw;  // low address bits of the word
    logic       done_bit;
    logic       hold_sel;   // use held address/bank

    always_comb begin
        ctrl_word = '{
            rcw:        cmd_word.rcw,
            odt:        cmd_word.odt,
            cke_dis:    cmd_word.cke_dis,
            sel:        cmd_word.sel,
            dq_en:      cmd_word.dq_en,
            dqs_en:     cmd_word.dqs_en,
            dqs_toggle: cmd_word.dqs_toggle,
            dci_en:     cmd_word.dci_en,
            buf_wr:     cmd_word.buf_wr,
            buf_rd:     cmd_word.buf_rd,
            buf_rst:    cmd_word.buf_rst
        };
        ctrl_pause     = ctrl_word;
        ctrl_pause.rcw = '0;                // a replayed command is always a nop
    end

    assign ctrl = add_pause ? ctrl_held : ctrl_word;

    assign cmd_nop  = (cmd_word.rcw == '0) && !add_pause; // inserted pauses do not count
    assign hold_sel = cmd_nop || add_pause;

    assign addr_calm = hold_sel ? addr_held : cmd_word.addr;
    assign bank_calm = hold_sel ? bank_held : cmd_word.bank;

    // pause length and done flag share the address field of a nop
    assign done_bit      = cmd_word.addr[CMD_DONE_BIT];
    assign pause_raw     = cmd_word.addr[CMD_PAUSE_BITS-1:0];
    assign sequence_done = cmd_nop && done_bit;
    assign pause_len     = done_bit ? '0 : pause_raw; // done wins over any length
    assign add_pause_req = cmd_word.add_pause_req;

    assign buf_wr  = ctrl.buf_wr;  // strobes follow the substituted controls
    assign buf_rd  = ctrl.buf_rd;
    assign buf_rst = ctrl.buf_rst;

    // held copy, loads on every cycle that is not a plain nop
    always_ff @(posedge mclk) begin
        if (mrst) begin
            addr_held <= '0;
            bank_held <= '0;
            ctrl_held <= '0;      // pause after reset drives nothing
        end else if (!cmd_nop) begin
            addr_held <= cmd_word.addr;
            bank_held <= cmd_word.bank;
            ctrl_held <= ctrl_pause;
        end
    end

    // pins stay put through a nop unless a pause just reloaded the hold
    assert property (@(posedge mclk) disable iff (mrst)
        (cmd_nop && !$past(add_pause) && !$past(mrst)) |->
            ($stable(addr_calm) && $stable(bank_calm)))
        else $error("address or bank moved during a nop");

endmodule

/* design/phy_cmd_pkg.sv */
// ##########################################################
// shared widths, types and command word layout for the
// half-rate DDR3 PHY command front end
// ##########################################################
package phy_cmd_pkg;

    localparam int ADDRESS_NUMBER = 15; // row/column bits, must fit the 32-bit word

    typedef logic [ADDRESS_NUMBER-1:0] row_addr_t; // one DDR3 address
    typedef logic [2:0]                bank_t;     // bank address
    typedef logic [2:0]                rcw_t;      // positive {ras,cas,we}, 0 is nop
    typedef logic [7:0]                tri_word_t; // one bit per DDR bit time
    typedef logic [3:0]                tri_pattern_t; // repeated twice per mclk

    // command word as sent by the sequencer, msb first
    typedef struct packed {
        row_addr_t addr;          // address, or pause length / done on a nop
        bank_t     bank;
        rcw_t      rcw;
        logic      odt;
        logic      cke_dis;       // xor-ed with the ddr_cke level
        logic      sel;           // 1: command in first half-cycle
        logic      dq_en;         // drive DQ
        logic      dqs_en;        // drive DQS
        logic      dqs_toggle;    // send dqs_pattern
        logic      dci_en;
        logic      buf_wr;        // external buffer write
        logic      buf_rd;        // external buffer read
        logic      add_pause_req; // ask for one extra pause cycle
        logic      buf_rst;       // buffer address back to page start
    } cmd_word_t;

    // controls active in the current cycle, after pause substitution
    typedef struct packed {
        rcw_t rcw;
        logic odt;
        logic cke_dis;
        logic sel;
        logic dq_en;
        logic dqs_en;
        logic dqs_toggle;
        logic dci_en;
        logic buf_wr;
        logic buf_rd;
        logic buf_rst;
    } cmd_ctrl_t;

    // two half-cycle command slots, index 1 goes out first
    typedef struct packed {
        row_addr_t [1:0] addr;
        bank_t     [1:0] bank;
        logic      [1:0] ras_n;
        logic      [1:0] cas_n;
        logic      [1:0] we_n;
        logic      [1:0] cke;
        logic      [1:0] odt;
    } phy_slots_t;

endpackage
